// ==== sim.f ====
+incdir+hdl
hdl/pov_pkg.sv
hdl/hall_filter.sv
hdl/hall_sensor.sv
hdl/column_store.sv
hdl/led_link.sv
hdl/pov_display.sv
verification/pov_clock_gen.sv
verification/tb_pov_display.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/10ps -f sim.f \
    --top-module tb_pov_display -o tb_pov_display &&
./obj_dir/tb_pov_display || exit 1

// ==== verification/tb_pov_display.sv ====
`timescale 1ns/10ps
`include "pov_settings.svh"

module tb_pov_display;

    import pov_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 5;
    localparam int          DRIVE_DELAY  = 2;
    localparam logic [31:0] SEED         = 32'hdc32_291b;

    // Rotor model with eight clock cycles per slice
    localparam int SLICES         = 2 * `POV_SLICES_PER_HALF;
    localparam int HALF_TURN      = 8 * `POV_SLICES_PER_HALF;
    localparam int TURN_CYCLES    = 2 * HALF_TURN;
    localparam int PULSE_CYCLES   = 2 * `POV_DEBOUNCE_CYCLES;
    localparam int QUIET_CYCLES   = 64;
    localparam int BUSY_ACK_DELAY = 30;

    // About seven turns of rotation and listening windows in all tests
    // The limit doubles that and adds room for reset, frame loading and draining
    localparam int TEST_TURNS     = 7;
    localparam int TIMEOUT_CYCLES = 2 * TEST_TURNS * TURN_CYCLES + 12000;

    logic    clk;
    logic    nrst;
    logic    hall_1;
    logic    hall_2;
    logic    wr_en;
    slice_t  wr_slice;
    column_t wr_column;
    logic    led_req;
    slice_t  led_slice;
    column_t led_column;
    logic    led_ack;

    // Reference copy of what the column memory should hold
    column_t frame [SLICES];

    // Every column accepted by the LED driver model in arrival order
    slice_t  got_slice [$];
    column_t got_column [$];

    // Cycles the driver model waits before it acknowledges
    int ack_delay = 0;
    int cycle_count = 0;

    // Previous cycle of the output bus as seen by the handshake monitor
    logic    prev_req = 1'b0;
    logic    prev_ack = 1'b0;
    slice_t  prev_slice;
    column_t prev_column;

    pov_clock_gen #(
        .CLK_PERIOD   (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk  (clk),
        .nrst (nrst)
    );

    pov_display uut (
        .clk        (clk),
        .nrst       (nrst),
        .hall_1     (hall_1),
        .hall_2     (hall_2),
        .wr_en      (wr_en),
        .wr_slice   (wr_slice),
        .wr_column  (wr_column),
        .led_req    (led_req),
        .led_slice  (led_slice),
        .led_column (led_column),
        .led_ack    (led_ack)
    );

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("** FAIL **");
        $fatal(1, "simulation stopped after the first error");
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("mismatch in %s, %s: expected 0x%0h, actual 0x%0h",
                                    test_name, what, expected, actual));
        end
    endtask

    // LED driver model
    // Each request is recorded, acknowledged after ack_delay cycles,
    // and the acknowledge is dropped once the request has gone low
    initial begin : driver_model
        led_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (led_req && !led_ack) begin
                got_slice.push_back(led_slice);
                got_column.push_back(led_column);
                repeat (ack_delay) @(posedge clk);
                #DRIVE_DELAY led_ack = 1'b1;
                @(posedge clk);
                while (led_req) @(posedge clk);
                #DRIVE_DELAY led_ack = 1'b0;
            end
        end
    end

    // Four-phase rule on the output bus for the whole run
    always @(posedge clk) begin
        if (nrst) begin
            // The acknowledge must already be low in the cycle where the request rises
            if (led_req && !prev_req && prev_ack) begin
                stop_on_error("led_req rose while led_ack was still high");
            end
            if (led_req && prev_req &&
                (led_slice != prev_slice || led_column != prev_column)) begin
                stop_on_error("led_slice or led_column changed while led_req was high");
            end
        end
        prev_req    <= led_req;
        prev_ack    <= led_ack;
        prev_slice  <= led_slice;
        prev_column <= led_column;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("timeout, the run did not finish within %0d cycles",
                                    TIMEOUT_CYCLES));
        end
    end

    // Magnet passing one sensor, which pulls it low for a number of cycles
    task automatic pulse_sensor(input bit second, input int cycles);
        @(posedge clk);
        #DRIVE_DELAY;
        if (second) begin
            hall_2 = 1'b0;
        end else begin
            hall_1 = 1'b0;
        end
        repeat (cycles) @(posedge clk);
        #DRIVE_DELAY;
        hall_1 = 1'b1;
        hall_2 = 1'b1;
    endtask

    // Falling edges of consecutive calls land exactly HALF_TURN cycles apart
    task automatic rotate_half(input bit second);
        pulse_sensor(second, PULSE_CYCLES);
        repeat (HALF_TURN - PULSE_CYCLES - 1) @(posedge clk);
    endtask

    task automatic spin_rotor(input int turns);
        for (int t = 0; t < turns; t++) begin
            rotate_half(1'b0);
            rotate_half(1'b1);
        end
    endtask

    // Leaves wr_en high so that writes can follow back to back
    task automatic write_column(input slice_t slice, input column_t column);
        @(posedge clk);
        #DRIVE_DELAY;
        wr_en     = 1'b1;
        wr_slice  = slice;
        wr_column = column;
        frame[slice] = column;
    endtask

    task automatic end_writes();
        @(posedge clk);
        #DRIVE_DELAY;
        wr_en = 1'b0;
    endtask

    task automatic load_frame();
        for (int i = 0; i < SLICES; i++) begin
            write_column(8'(i), frame[8'(i)]);
        end
        end_writes();
    endtask

    task automatic count_requests(input int cycles, output int seen);
        seen = 0;
        repeat (cycles) begin
            @(posedge clk);
            if (led_req) begin
                seen++;
            end
        end
    endtask

    // Strobes come every slice period, so a long silence means the link is drained
    task automatic wait_link_quiet();
        int quiet;
        quiet = 0;
        while (quiet < QUIET_CYCLES) begin
            @(posedge clk);
            if (led_req || led_ack) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
    endtask

    // The last full turn must show every slice once, in order, after a calibration
    // turn that itself ended on the last slice
    task automatic check_full_turn(input string test_name);
        int base;
        base = got_slice.size() - SLICES;
        if (base < 1) begin
            stop_on_error($sformatf("%s delivered only %0d columns", test_name,
                                    got_slice.size()));
        end
        check_value(test_name, "slice before the turn", 32'(SLICES - 1),
                    32'(got_slice[base - 1]));
        for (int i = 0; i < SLICES; i++) begin
            check_value(test_name, $sformatf("slice of entry %0d", i), 32'(i),
                        32'(got_slice[base + i]));
            check_value(test_name, $sformatf("column of slice %0d", i),
                        32'(frame[8'(i)]), 32'(got_column[base + i]));
        end
    endtask

    task automatic test_reset_idle();
        int seen;
        count_requests(200, seen);
        check_value("test_reset_idle", "request cycles", 32'd0, 32'(seen));
    endtask

    // No period has been measured yet, so the top shows slice 0 only
    task automatic test_first_top();
        int mark;
        mark = got_slice.size();
        pulse_sensor(1'b0, PULSE_CYCLES);
        repeat (HALF_TURN) @(posedge clk);
        check_value("test_first_top", "column count", 32'd1, 32'(got_slice.size() - mark));
        check_value("test_first_top", "slice", 32'd0, 32'(got_slice[mark]));
        check_value("test_first_top", "column", 32'(frame[8'd0]), 32'(got_column[mark]));
    endtask

    task automatic test_steady_rotation();
        ack_delay = 0;
        spin_rotor(2);
        wait_link_quiet();
        check_full_turn("test_steady_rotation");
    endtask

    task automatic test_back_pressure();
        int mark;
        mark = got_slice.size();
        ack_delay = BUSY_ACK_DELAY;
        spin_rotor(2);
        wait_link_quiet();
        ack_delay = 0;
        if (got_slice.size() <= mark) begin
            stop_on_error("test_back_pressure delivered no column");
        end
        if (got_slice.size() - mark >= 2 * SLICES) begin
            stop_on_error("test_back_pressure never dropped a column, the link kept up");
        end
        // The first strobe finds the link idle and the last one is never overwritten
        check_value("test_back_pressure", "first slice", 32'd0, 32'(got_slice[mark]));
        check_value("test_back_pressure", "last slice", 32'(SLICES - 1), 32'(got_slice[$]));
        for (int i = mark; i < got_slice.size(); i++) begin
            check_value("test_back_pressure", $sformatf("column of slice %0d", got_slice[i]),
                        32'(frame[got_slice[i]]), 32'(got_column[i]));
            // Going backwards is only allowed when the next turn begins
            if (i > mark && got_slice[i] <= got_slice[i - 1]) begin
                if (got_slice[i - 1] < 8'(`POV_SLICES_PER_HALF) ||
                    got_slice[i] >= 8'(`POV_SLICES_PER_HALF)) begin
                    stop_on_error($sformatf("test_back_pressure sent slice %0d after %0d",
                                            got_slice[i], got_slice[i - 1]));
                end
            end
        end
    endtask

    task automatic test_glitch_reject();
        int mark;
        int seen;
        mark = got_slice.size();
        pulse_sensor(1'b0, `POV_DEBOUNCE_CYCLES - 1);
        count_requests(HALF_TURN, seen);
        check_value("test_glitch_reject", "request cycles", 32'd0, 32'(seen));
        check_value("test_glitch_reject", "columns delivered", 32'd0,
                    32'(got_slice.size() - mark));
    endtask

    // Inverted columns at spread slices including both ends of the frame
    task automatic test_live_update();
        for (int i = 0; i < 6; i++) begin
            write_column(8'(i * 51), ~frame[8'(i * 51)]);
        end
        end_writes();
        spin_rotor(2);
        wait_link_quiet();
        check_full_turn("test_live_update");
    endtask

    initial begin : main_sequence
        void'($urandom(SEED));
        hall_1    = 1'b1;
        hall_2    = 1'b1;
        wr_en     = 1'b0;
        wr_slice  = '0;
        wr_column = '0;
        for (int i = 0; i < SLICES; i++) begin
            frame[8'(i)] = column_t'($urandom);
        end
        @(posedge nrst);
        test_reset_idle();
        load_frame();
        test_first_top();
        test_steady_rotation();
        test_back_pressure();
        test_glitch_reject();
        test_live_update();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== verification/pov_clock_gen.sv ====
`timescale 1ns/10ps

module pov_clock_gen #(
    parameter int CLK_PERIOD   = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic nrst
);

    // Free-running clock with a 50 percent duty cycle
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reset is held for a fixed number of rising edges
    // Release happens just after an edge, like every other stimulus
    initial begin
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 nrst = 1'b1;
    end

endmodule

// ==== hdl/pov_display.sv ====
`timescale 1ns/10ps

module pov_display (
    input  logic             clk,
    input  logic             nrst,
    input  logic             hall_1,
    input  logic             hall_2,
    input  logic             wr_en,
    input  pov_pkg::slice_t  wr_slice,
    input  pov_pkg::column_t wr_column,
    output logic             led_req,
    output pov_pkg::slice_t  led_slice,
    output pov_pkg::column_t led_column,
    input  logic             led_ack
);

    import pov_pkg::*;

    // Filtered sensors, still active low
    logic hall_1_clean;
    logic hall_2_clean;

    // Slice strobe and its angular position
    logic   position_sync;
    slice_t slice_cnt;

    // Column fetched for the strobed slice
    logic    col_valid;
    slice_t  col_slice;
    column_t col_data;

    hall_filter u_hall_filter (
        .clk          (clk),
        .nrst         (nrst),
        .hall_1       (hall_1),
        .hall_2       (hall_2),
        .hall_1_clean (hall_1_clean),
        .hall_2_clean (hall_2_clean)
    );

    hall_sensor u_hall_sensor (
        .clk           (clk),
        .nrst          (nrst),
        .hall_1_clean  (hall_1_clean),
        .hall_2_clean  (hall_2_clean),
        .slice_cnt     (slice_cnt),
        .position_sync (position_sync)
    );

    column_store u_column_store (
        .clk           (clk),
        .nrst          (nrst),
        .position_sync (position_sync),
        .slice_cnt     (slice_cnt),
        .wr_en         (wr_en),
        .wr_slice      (wr_slice),
        .wr_column     (wr_column),
        .col_valid     (col_valid),
        .col_slice     (col_slice),
        .col_data      (col_data)
    );

    led_link u_led_link (
        .clk        (clk),
        .nrst       (nrst),
        .col_valid  (col_valid),
        .col_slice  (col_slice),
        .col_data   (col_data),
        .led_req    (led_req),
        .led_slice  (led_slice),
        .led_column (led_column),
        .led_ack    (led_ack)
    );

endmodule

// ==== hdl/led_link.sv ====
`timescale 1ns/10ps

module led_link (
    input  logic             clk,
    input  logic             nrst,
    input  logic             col_valid,
    input  pov_pkg::slice_t  col_slice,
    input  pov_pkg::column_t col_data,
    output logic             led_req,
    output pov_pkg::slice_t  led_slice,
    output pov_pkg::column_t led_column,
    input  logic             led_ack
);

    import pov_pkg::*;

    link_state_t state;

    // One-deep holding register for a column that arrived while busy
    logic    pend_valid;
    slice_t  pend_slice;
    column_t pend_column;

    // A new request may start only when no handshake is open
    // and the driver has dropped its acknowledge
    logic can_launch;
    logic launch;

    assign can_launch = (state == link_idle || state == link_wait_release) && !led_ack;
    assign launch     = can_launch && (col_valid || pend_valid);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= link_idle;
            pend_valid <= 1'b0;
        end else begin
            // Whatever is sent, nothing older stays pending
            if (launch) begin
                pend_valid <= 1'b0;
            end else if (col_valid) begin
                pend_valid <= 1'b1;
            end
            case (state)
                link_idle: begin
                    if (launch) begin
                        state <= link_req;
                    end
                end
                link_req: begin
                    if (led_ack) begin
                        state <= link_wait_release;
                    end
                end
                link_wait_release: begin
                    // Chain straight into the next request if one is waiting
                    if (launch) begin
                        state <= link_req;
                    end else if (!led_ack) begin
                        state <= link_idle;
                    end
                end
                default: begin
                    state <= link_idle;
                end
            endcase
        end
    end

    // Payload registers
    // The newest column wins, both on launch and in the holding register
    always_ff @(posedge clk) begin
        if (launch) begin
            led_slice  <= col_valid ? col_slice : pend_slice;
            led_column <= col_valid ? col_data : pend_column;
        end else if (col_valid) begin
            pend_slice  <= col_slice;
            pend_column <= col_data;
        end
    end

    // Request is a decoded state flop, so it never glitches
    assign led_req = (state == link_req);

endmodule

// ==== hdl/column_store.sv ====
`timescale 1ns/10ps
`include "pov_settings.svh"

module column_store (
    input  logic             clk,
    input  logic             nrst,
    input  logic             position_sync,
    input  pov_pkg::slice_t  slice_cnt,
    input  logic             wr_en,
    input  pov_pkg::slice_t  wr_slice,
    input  pov_pkg::column_t wr_column,
    output logic             col_valid,
    output pov_pkg::slice_t  col_slice,
    output pov_pkg::column_t col_data
);

    import pov_pkg::*;

    // One column per slice over the whole turn
    localparam int DEPTH = 2 * `POV_SLICES_PER_HALF;

    column_t mem [DEPTH];

    // Host write port
    // The frame starts dark after reset so an unwritten slice shows nothing
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_slice] <= wr_column;
        end
    end

    // Strobe-driven read
    // A write to the same slice in the strobe cycle lands after the read,
    // so the old column is delivered
    always_ff @(posedge clk) begin
        if (position_sync) begin
            col_slice <= slice_cnt;
            col_data  <= mem[slice_cnt];
        end
    end

    // The valid strobe trails position_sync by exactly one cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            col_valid <= 1'b0;
        end else begin
            col_valid <= position_sync;
        end
    end

endmodule

// ==== hdl/hall_sensor.sv ====
`timescale 1ns/10ps
`include "pov_settings.svh"

module hall_sensor (
    input  logic            clk,
    input  logic            nrst,
    input  logic            hall_1_clean,
    input  logic            hall_2_clean,
    output pov_pkg::slice_t slice_cnt,
    output logic            position_sync
);

    import pov_pkg::*;

    // Bits of the slice index inside one half turn
    localparam int SLICE_BITS = $clog2(`POV_SLICES_PER_HALF);
    localparam int SP_W       = `POV_PERIOD_WIDTH - SLICE_BITS;

    // Last slice index of a half turn, the index saturates here
    localparam logic [SLICE_BITS-1:0] LAST_IDX = SLICE_BITS'(`POV_SLICES_PER_HALF - 1);

    // One-cycle pulse when a sensor fires and the guard is clear
    logic top;

    // Set by a top and held until both sensors are released again
    logic guard;

    // Sensor that started the current half turn
    half_turn_t half_turn;

    // Cycles since the last top
    // Zero means no top has been seen yet, so the first period reads as zero
    period_t period_cnt;

    // Cycles per slice, taken from the previous half turn
    logic [SP_W-1:0] slice_period;
    logic [SP_W-1:0] slice_last;

    // Cycles spent in the current slice
    logic [SP_W-1:0] slice_cycle_cnt;

    // Slice index inside the current half turn
    logic [SLICE_BITS-1:0] slice_idx;

    // Top generation from the filtered sensors
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            top       <= 1'b0;
            guard     <= 1'b0;
            half_turn <= half_turn_1;
        end else begin
            top <= 1'b0;
            if ((!hall_1_clean || !hall_2_clean) && !guard) begin
                top   <= 1'b1;
                guard <= 1'b1;
                // Sensor 1 wins if both happen to fall together
                if (!hall_1_clean) begin
                    half_turn <= half_turn_1;
                end else begin
                    half_turn <= half_turn_2;
                end
            end
            // The next top is only armed once the magnet has passed
            if (hall_1_clean && hall_2_clean) begin
                guard <= 1'b0;
            end
        end
    end

    // Half-turn period measurement
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            period_cnt   <= '0;
            slice_period <= '0;
        end else begin
            if (top) begin
                // Dividing by the slice count is just dropping the low bits
                slice_period <= period_cnt[`POV_PERIOD_WIDTH-1:SLICE_BITS];
                period_cnt   <= period_t'(1);
            end else if (period_cnt != '0 && period_cnt != '1) begin
                // Saturate so that a stalled rotor does not wrap to a short period
                period_cnt <= period_cnt + 1'b1;
            end
        end
    end

    assign slice_last = slice_period - 1'b1;

    // Slice boundaries inside the half turn
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            position_sync   <= 1'b0;
            slice_cycle_cnt <= '0;
            slice_idx       <= '0;
        end else begin
            position_sync <= 1'b0;
            if (top) begin
                // Each top realigns the slice grid and shows the first slice
                position_sync   <= 1'b1;
                slice_cycle_cnt <= '0;
                slice_idx       <= '0;
            end else if (slice_period != '0 && slice_idx != LAST_IDX) begin
                if (slice_cycle_cnt == slice_last) begin
                    position_sync   <= 1'b1;
                    slice_cycle_cnt <= '0;
                    slice_idx       <= slice_idx + 1'b1;
                end else begin
                    slice_cycle_cnt <= slice_cycle_cnt + 1'b1;
                end
            end
        end
    end

    // The second half turn is offset by one half of the full frame
    always_comb begin
        if (half_turn == half_turn_2) begin
            slice_cnt = slice_t'(`POV_SLICES_PER_HALF) + slice_t'(slice_idx);
        end else begin
            slice_cnt = slice_t'(slice_idx);
        end
    end

endmodule

// ==== hdl/hall_filter.sv ====
`timescale 1ns/10ps
`include "pov_settings.svh"

module hall_filter (
    input  logic clk,
    input  logic nrst,
    input  logic hall_1,
    input  logic hall_2,
    output logic hall_1_clean,
    output logic hall_2_clean
);

    // Wide enough to hold the full debounce length
    localparam int CNT_W = $clog2(`POV_DEBOUNCE_CYCLES + 1);

    // Both channels are handled as a two-bit vector, bit 0 is sensor 1
    logic [1:0] raw;
    logic [1:0] sync_1;
    logic [1:0] sync_2;
    logic [1:0] clean;

    // Number of consecutive synchronized samples that differ from clean
    logic [CNT_W-1:0] stable_cnt [2];

    assign raw = {hall_2, hall_1};

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            // Sensors are active low, so high means nothing detected
            sync_1 <= '1;
            sync_2 <= '1;
            clean  <= '1;
            for (int i = 0; i < 2; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            // Two flops per channel to tame metastability
            sync_1 <= raw;
            sync_2 <= sync_1;
            for (int i = 0; i < 2; i++) begin
                if (sync_2[i] != clean[i]) begin
                    // The new level must persist for the full debounce length
                    if (stable_cnt[i] == CNT_W'(`POV_DEBOUNCE_CYCLES - 1)) begin
                        clean[i]      <= sync_2[i];
                        stable_cnt[i] <= '0;
                    end else begin
                        stable_cnt[i] <= stable_cnt[i] + 1'b1;
                    end
                end else begin
                    // Any sample back at the old level restarts the count
                    stable_cnt[i] <= '0;
                end
            end
        end
    end

    assign hall_1_clean = clean[0];
    assign hall_2_clean = clean[1];

endmodule

// ==== hdl/pov_pkg.sv ====
`include "pov_settings.svh"

package pov_pkg;

    // Angular slice number over a full turn
    // The top bit tells which half turn the slice belongs to
    typedef logic [7:0] slice_t;

    // One LED column, bit i drives LED i
    typedef logic [`POV_LED_COUNT-1:0] column_t;

    // Cycle count used to measure a half turn
    typedef logic [`POV_PERIOD_WIDTH-1:0] period_t;

    // Which sensor started the half turn in progress
    typedef enum logic {
        half_turn_1,
        half_turn_2
    } half_turn_t;

    // Four-phase handshake towards the LED driver
    typedef enum logic [1:0] {
        link_idle,
        link_req,
        link_wait_release
    } link_state_t;

endpackage

// ==== hdl/pov_settings.svh ====
`ifndef POV_SETTINGS_SVH
`define POV_SETTINGS_SVH

// Angular resolution of one half turn
// The tracker divides each measured half turn into this many slices
// Must be a power of two so that the slice period is a plain shift
`define POV_SLICES_PER_HALF 128

// Number of LEDs on the rotating arm, one bit per LED in a column
`define POV_LED_COUNT 16

// Consecutive equal synchronized samples a Hall input must show
// before its filtered level is allowed to change
`define POV_DEBOUNCE_CYCLES 4

// Width of the half-turn cycle counter
// At 50 MHz this covers a half turn of roughly a third of a second
`define POV_PERIOD_WIDTH 24

`endif
